// ==== logic/fetchPkg.sv ====
`default_nettype none

package fetchPkg;

    // width of a RISC-V major opcode field
    localparam int OPC_W = 7;
    // destination register index width
    localparam int RD_W = 5;

    // next-PC source from execute, same encoding as the core
    // 00 sequential, 01 branch or JAL target, 10 JALR result
    typedef enum logic [1:0] {
        pcSeq    = 2'b00,
        pcBranch = 2'b01,
        pcJalr   = 2'b10
    } pcSrcT;

    // coarse class handed to decode
    typedef enum logic [2:0] {
        kindAlu    = 3'd0,
        kindLoad   = 3'd1,
        kindStore  = 3'd2,
        kindBranch = 3'd3,
        kindJal    = 3'd4,
        kindJalr   = 3'd5,
        kindOther  = 3'd6
    } instrKindT;

    // RV32I major opcodes, instr[6:0]
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPC_W-1:0] OPC_OPIMM  = 7'b0010011;

endpackage

`default_nettype wire

// ==== logic/fetchSlotIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// one pipeline stage's worth of fetched instructions
interface fetchSlotIf #(
    parameter int WIDTH = 32
);

    // address of slot 1, slot 2 sits at basePc + 4
    logic [WIDTH-1:0] basePc;
    // older instruction
    logic [WIDTH-1:0] instr1;
    // younger instruction
    logic [WIDTH-1:0] instr2;
    // bundle holds a live fetch
    logic             valid;

    // producing stage
    modport src (
        output basePc,
        output instr1,
        output instr2,
        output valid
    );

    // consuming stage, samples every unstalled edge
    modport snk (
        input basePc,
        input instr1,
        input instr2,
        input valid
    );

endinterface

`default_nettype wire

// ==== logic/dualPcUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

// fetch PC register for the two-wide front end
module dualPcUnit
    import fetchPkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    // slot 1 execute, the older one
    input  pcSrcT            pcSrc1,
    input  logic [WIDTH-1:0] target1,
    input  logic [WIDTH-1:0] aluResult1,
    // slot 2 execute
    input  pcSrcT            pcSrc2,
    input  logic [WIDTH-1:0] target2,
    input  logic [WIDTH-1:0] aluResult2,
    output logic [WIDTH-1:0] fetchPc,
    output logic             redirect
);

    // sequential step covers both slots
    localparam logic [WIDTH-1:0] PAIR_STEP = WIDTH'(8);

    logic [WIDTH-1:0] seqPc;
    logic [WIDTH-1:0] slot1Target;
    logic [WIDTH-1:0] slot2Target;
    logic [WIDTH-1:0] nextPc;

    // resolve one slot's redirect address
    function automatic logic [WIDTH-1:0] pickTarget(
        input pcSrcT            src,
        input logic [WIDTH-1:0] target,
        input logic [WIDTH-1:0] aluResult
    );
        logic [WIDTH-1:0] result;
        // JALR drops the low two bits
        if (src == pcJalr) begin
            result = {aluResult[WIDTH-1:2], 2'b00};
        end else begin
            result = target;
        end
        return result;
    endfunction

    assign seqPc       = fetchPc + PAIR_STEP;
    assign slot1Target = pickTarget(pcSrc1, target1, aluResult1);
    assign slot2Target = pickTarget(pcSrc2, target2, aluResult2);

    // any slot leaving the sequential path
    // also acts as flush for stages 1 and 2
    assign redirect = (pcSrc1 != pcSeq) || (pcSrc2 != pcSeq);

    always_comb begin
        // slot 1 is older, its redirect wins
        if (pcSrc1 != pcSeq) begin
            nextPc = slot1Target;
        end else if (pcSrc2 != pcSeq) begin
            nextPc = slot2Target;
        end else begin
            nextPc = seqPc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchPc <= '0;
        end else if (redirect || !stall) begin
            // a redirect goes through even while stalled
            fetchPc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dualInstrRom.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 1, registered dual read of the instruction memory
module dualInstrRom #(
    parameter int WIDTH     = 32,
    parameter int ROM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         redirect,
    input  logic [WIDTH-1:0]             fetchPc,
    // load port, word index
    input  logic                         progWe,
    input  logic [$clog2(ROM_WORDS)-1:0] progAddr,
    input  logic [WIDTH-1:0]             progData,
    fetchSlotIf.src                      stageOut
);

    localparam int IDX_W = $clog2(ROM_WORDS);

    logic [WIDTH-1:0] mem [ROM_WORDS];
    logic [IDX_W-1:0] idx1;
    logic [IDX_W-1:0] idx2;

    // byte address to word index, upper bits fall away
    // so the address wraps at the memory depth
    assign idx1 = fetchPc[IDX_W+1:2];
    // slot 2 word, wraps the same way
    assign idx2 = idx1 + 1'b1;

    // program load
    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    // payload, only valid qualifies it
    always_ff @(posedge clk) begin
        if (!stall) begin
            stageOut.basePc <= fetchPc;
            stageOut.instr1 <= mem[idx1];
            stageOut.instr2 <= mem[idx2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stageOut.valid <= 1'b0;
        end else if (redirect) begin
            // drop the fetch of the wrong path
            stageOut.valid <= 1'b0;
        end else if (!stall) begin
            stageOut.valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/slotPredecode.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 2, class and rd for both slots
module slotPredecode
    import fetchPkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             redirect,
    fetchSlotIf.snk          stageIn,
    output logic             outValid,
    output logic [WIDTH-1:0] outPc,
    output logic [WIDTH-1:0] outInstr1,
    output logic [WIDTH-1:0] outInstr2,
    output instrKindT        outKind1,
    output instrKindT        outKind2,
    output logic [RD_W-1:0]  outRd1,
    output logic [RD_W-1:0]  outRd2
);

    instrKindT       kind1;
    instrKindT       kind2;
    logic [RD_W-1:0] rd1;
    logic [RD_W-1:0] rd2;

    // major opcode to class
    function automatic instrKindT classify(input logic [OPC_W-1:0] opcode);
        instrKindT kind;
        case (opcode)
            OPC_OP, OPC_OPIMM: kind = kindAlu;
            OPC_LOAD:          kind = kindLoad;
            OPC_STORE:         kind = kindStore;
            OPC_BRANCH:        kind = kindBranch;
            OPC_JAL:           kind = kindJal;
            OPC_JALR:          kind = kindJalr;
            // lui, auipc, system and the rest
            default:           kind = kindOther;
        endcase
        return kind;
    endfunction

    // store and branch reuse bits 11:7 for the immediate
    function automatic logic [RD_W-1:0] destReg(
        input logic [WIDTH-1:0] instr,
        input instrKindT        kind
    );
        logic [RD_W-1:0] rd;
        if (kind == kindStore || kind == kindBranch) begin
            rd = '0;
        end else begin
            rd = instr[11:7];
        end
        return rd;
    endfunction

    assign kind1 = classify(stageIn.instr1[OPC_W-1:0]);
    assign kind2 = classify(stageIn.instr2[OPC_W-1:0]);
    assign rd1   = destReg(stageIn.instr1, kind1);
    assign rd2   = destReg(stageIn.instr2, kind2);

    // output payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            outPc     <= stageIn.basePc;
            outInstr1 <= stageIn.instr1;
            outInstr2 <= stageIn.instr2;
            outKind1  <= kind1;
            outKind2  <= kind2;
            outRd1    <= rd1;
            outRd2    <= rd2;
        end
    end

    // same flush and hold rules as stage 1
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (redirect) begin
            outValid <= 1'b0;
        end else if (!stall) begin
            outValid <= stageIn.valid;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dualFetchFrontEnd.sv ====
`timescale 1ns/1ps
`default_nettype none

// two-wide fetch: PC register, memory read, predecode
module dualFetchFrontEnd
    import fetchPkg::*;
#(
    parameter int WIDTH     = 32,
    parameter int ROM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    // global hold for every stage
    input  logic                         stall,
    // redirect from execute, slot 1
    input  pcSrcT                        pcSrc1,
    input  logic [WIDTH-1:0]             target1,
    input  logic [WIDTH-1:0]             aluResult1,
    // redirect from execute, slot 2
    input  pcSrcT                        pcSrc2,
    input  logic [WIDTH-1:0]             target2,
    input  logic [WIDTH-1:0]             aluResult2,
    // program load, meant for use under reset
    input  logic                         progWe,
    input  logic [$clog2(ROM_WORDS)-1:0] progAddr,
    input  logic [WIDTH-1:0]             progData,
    // to decode
    output logic                         outValid,
    output logic [WIDTH-1:0]             outPc,
    output logic [WIDTH-1:0]             outInstr1,
    output logic [WIDTH-1:0]             outInstr2,
    output instrKindT                    outKind1,
    output instrKindT                    outKind2,
    output logic [RD_W-1:0]              outRd1,
    output logic [RD_W-1:0]              outRd2
);

    logic [WIDTH-1:0] fetchPc;
    // flush for both later stages
    logic             redirect;

    // stage 1 to stage 2 bundle
    fetchSlotIf #(.WIDTH(WIDTH)) romToPre ();

    dualPcUnit #(
        .WIDTH(WIDTH)
    ) i_dualPcUnit (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .pcSrc1    (pcSrc1),
        .target1   (target1),
        .aluResult1(aluResult1),
        .pcSrc2    (pcSrc2),
        .target2   (target2),
        .aluResult2(aluResult2),
        .fetchPc   (fetchPc),
        .redirect  (redirect)
    );

    dualInstrRom #(
        .WIDTH    (WIDTH),
        .ROM_WORDS(ROM_WORDS)
    ) i_dualInstrRom (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .redirect(redirect),
        .fetchPc (fetchPc),
        .progWe  (progWe),
        .progAddr(progAddr),
        .progData(progData),
        .stageOut(romToPre.src)
    );

    slotPredecode #(
        .WIDTH(WIDTH)
    ) i_slotPredecode (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .redirect (redirect),
        .stageIn  (romToPre.snk),
        .outValid (outValid),
        .outPc    (outPc),
        .outInstr1(outInstr1),
        .outInstr2(outInstr2),
        .outKind1 (outKind1),
        .outKind2 (outKind2),
        .outRd1   (outRd1),
        .outRd2   (outRd2)
    );

endmodule

`default_nettype wire

// ==== verification/dualFetchFrontEnd_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

// output stage rules of the two-wide fetch front end
module dualFetchFrontEnd_assert
    import fetchPkg::*;
#(
    parameter int WIDTH = 32
) (
    input logic             clk,
    input logic             rst,
    input logic             stall,
    input pcSrcT            pcSrc1,
    input pcSrcT            pcSrc2,
    input logic             outValid,
    input logic [WIDTH-1:0] outPc,
    input logic [WIDTH-1:0] outInstr1,
    input logic [WIDTH-1:0] outInstr2,
    input instrKindT        outKind1,
    input instrKindT        outKind2,
    input logic [RD_W-1:0]  outRd1,
    input logic [RD_W-1:0]  outRd2
);

    // number of assertion failures so far
    int   failCount = 0;
    logic redirectNow;

    // either slot leaving the sequential path
    assign redirectNow = (pcSrc1 != pcSeq) || (pcSrc2 != pcSeq);

    // reset empties the output stage
    resetClears: assert property (@(posedge clk) rst |=> !outValid)
        else begin
            failCount++;
            $error("outValid is high in the cycle after reset");
        end

    // held stall freezes the whole output bundle
    stallHolds: assert property (@(posedge clk) disable iff (rst)
        (stall && !redirectNow) |=> $stable(outValid) && $stable(outPc)
            && $stable(outInstr1) && $stable(outInstr2) && $stable(outKind1)
            && $stable(outKind2) && $stable(outRd1) && $stable(outRd2))
        else begin
            failCount++;
            $error("outputs changed while stalled without a redirect");
        end

    // wrong-path bundles never show up
    flushEmpties: assert property (@(posedge clk) disable iff (rst)
        redirectNow |=> !outValid [*2])
        else begin
            failCount++;
            $error("outValid is high within two cycles of a redirect");
        end

endmodule

bind dualFetchFrontEnd dualFetchFrontEnd_assert #(
    .WIDTH(WIDTH)
) i_dualFetchFrontEnd_assert (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .pcSrc1   (pcSrc1),
    .pcSrc2   (pcSrc2),
    .outValid (outValid),
    .outPc    (outPc),
    .outInstr1(outInstr1),
    .outInstr2(outInstr2),
    .outKind1 (outKind1),
    .outKind2 (outKind2),
    .outRd1   (outRd1),
    .outRd2   (outRd2)
);

`default_nettype wire

// ==== verification/dualFetchFrontEnd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dualFetchFrontEnd_tb
    import fetchPkg::*;
#(
    parameter int WIDTH     = 32,
    // small memory so redirects wrap often
    parameter int ROM_WORDS = 64
);

    localparam int ADDR_W          = $clog2(ROM_WORDS);
    localparam int CYCLES_PER_TEST = 200;
    localparam int NUM_TESTS       = 5;
    localparam int CLK_PERIOD      = 20;
    // program load, reset and drain on top of the tests
    localparam int MARGIN_CYCLES   = ROM_WORDS + 100;
    localparam int TIMEOUT_NS      = (CYCLES_PER_TEST * NUM_TESTS + MARGIN_CYCLES) * CLK_PERIOD;
    // aligned targets over twice the memory, so fetches wrap
    localparam logic [WIDTH-1:0] TARGET_MASK = WIDTH'(ROM_WORDS * 8 - 4);
    // jalr results keep random low bits
    localparam logic [WIDTH-1:0] ALU_MASK    = WIDTH'(ROM_WORDS * 8 - 1);

    typedef struct packed {
        logic [WIDTH-1:0] instr1;
        logic [WIDTH-1:0] instr2;
        instrKindT        kind1;
        instrKindT        kind2;
        logic [RD_W-1:0]  rd1;
        logic [RD_W-1:0]  rd2;
    } bundleT;

    logic              clk = 1'b0;
    logic              rst;
    logic              stall;
    pcSrcT             pcSrc1;
    pcSrcT             pcSrc2;
    logic [WIDTH-1:0]  target1;
    logic [WIDTH-1:0]  aluResult1;
    logic [WIDTH-1:0]  target2;
    logic [WIDTH-1:0]  aluResult2;
    logic              progWe;
    logic [ADDR_W-1:0] progAddr;
    logic [WIDTH-1:0]  progData;
    logic              outValid;
    logic [WIDTH-1:0]  outPc;
    logic [WIDTH-1:0]  outInstr1;
    logic [WIDTH-1:0]  outInstr2;
    instrKindT         outKind1;
    instrKindT         outKind2;
    logic [RD_W-1:0]   outRd1;
    logic [RD_W-1:0]   outRd2;

    // testbench copy of the program
    logic [WIDTH-1:0] memModel [ROM_WORDS];
    // base PCs in flight, oldest first, tail is the PC register
    logic [WIDTH-1:0] pcQueue [$];
    integer           seed = 65;
    string            testName = "reset";
    int               acceptCount = 0;

    dualFetchFrontEnd #(
        .WIDTH    (WIDTH),
        .ROM_WORDS(ROM_WORDS)
    ) i_dualFetchFrontEnd (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .pcSrc1    (pcSrc1),
        .target1   (target1),
        .aluResult1(aluResult1),
        .pcSrc2    (pcSrc2),
        .target2   (target2),
        .aluResult2(aluResult2),
        .progWe    (progWe),
        .progAddr  (progAddr),
        .progData  (progData),
        .outValid  (outValid),
        .outPc     (outPc),
        .outInstr1 (outInstr1),
        .outInstr2 (outInstr2),
        .outKind1  (outKind1),
        .outKind2  (outKind2),
        .outRd1    (outRd1),
        .outRd2    (outRd2)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string test, input string field,
                              input logic [WIDTH-1:0] expected,
                              input logic [WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("error: test %s %s expected %h actual %h", test, field, expected, actual);
            failRun("first mismatch, run stops here");
        end
    endtask

    // class from the major opcode
    function automatic instrKindT expKind(input logic [OPC_W-1:0] opcode);
        instrKindT kind;
        case (opcode)
            OPC_OP:     kind = kindAlu;
            OPC_OPIMM:  kind = kindAlu;
            OPC_LOAD:   kind = kindLoad;
            OPC_STORE:  kind = kindStore;
            OPC_BRANCH: kind = kindBranch;
            OPC_JAL:    kind = kindJal;
            OPC_JALR:   kind = kindJalr;
            default:    kind = kindOther;
        endcase
        return kind;
    endfunction

    // expected bundle for a base PC
    function automatic bundleT refBundle(input logic [WIDTH-1:0] pc);
        bundleT b;
        int     w1;
        int     w2;
        w1 = int'((pc >> 2) % ROM_WORDS);
        w2 = (w1 + 1) % ROM_WORDS;
        b.instr1 = memModel[w1];
        b.instr2 = memModel[w2];
        b.kind1  = expKind(b.instr1[OPC_W-1:0]);
        b.kind2  = expKind(b.instr2[OPC_W-1:0]);
        // no rd field in stores and branches
        b.rd1 = (b.kind1 == kindStore || b.kind1 == kindBranch) ? '0 : b.instr1[11:7];
        b.rd2 = (b.kind2 == kindStore || b.kind2 == kindBranch) ? '0 : b.instr2[11:7];
        return b;
    endfunction

    // slot 1 first, jalr clears bits 1:0
    function automatic logic [WIDTH-1:0] expTarget();
        logic [WIDTH-1:0] t;
        if (pcSrc1 != pcSeq) begin
            t = (pcSrc1 == pcJalr) ? (aluResult1 & ~WIDTH'(3)) : target1;
        end else begin
            t = (pcSrc2 == pcJalr) ? (aluResult2 & ~WIDTH'(3)) : target2;
        end
        return t;
    endfunction

    // true once in odds draws, never for 0
    function automatic bit chance(input int odds);
        int unsigned r;
        r = $random(seed);
        return (odds != 0) && ((r % odds) == 0);
    endfunction

    function automatic pcSrcT randomKind();
        int r;
        r = $random(seed);
        return r[0] ? pcJalr : pcBranch;
    endfunction

    task automatic driveIdle();
        stall  = 1'b0;
        pcSrc1 = pcSeq;
        pcSrc2 = pcSeq;
    endtask

    task automatic runTest(input string name, input int stallOdds, input int slot1Odds,
                           input int slot2Odds, input int pairOdds);
        bit pair;
        testName = name;
        repeat (CYCLES_PER_TEST) begin
            pair       = chance(pairOdds);
            stall      = chance(stallOdds);
            target1    = $random(seed) & TARGET_MASK;
            target2    = $random(seed) & TARGET_MASK;
            aluResult1 = $random(seed) & ALU_MASK;
            aluResult2 = $random(seed) & ALU_MASK;
            pcSrc1     = pcSeq;
            pcSrc2     = pcSeq;
            if (pair || chance(slot1Odds)) begin
                pcSrc1 = randomKind();
            end
            if (pair || chance(slot2Odds)) begin
                pcSrc2 = randomKind();
            end
            @(posedge clk);
            #1;
        end
        driveIdle();
    endtask

    // one compare per cycle, inputs and outputs both settled
    always @(negedge clk) begin : compareProc
        logic [WIDTH-1:0] expPc;
        bundleT           exp;
        if (rst) begin
            checkValue("reset", "outValid", '0, WIDTH'(outValid));
            pcQueue.delete();
            pcQueue.push_back('0);
        end else begin
            if (outValid && !stall) begin
                if (pcQueue.size() < 2) begin
                    failRun("a bundle came out that was never fetched");
                end
                expPc = pcQueue.pop_front();
                if (acceptCount == 0) begin
                    checkValue("reset", "firstPc", '0, outPc);
                end
                exp = refBundle(expPc);
                checkValue(testName, "outPc", expPc, outPc);
                checkValue(testName, "outInstr1", exp.instr1, outInstr1);
                checkValue(testName, "outInstr2", exp.instr2, outInstr2);
                checkValue(testName, "outKind1", WIDTH'(exp.kind1), WIDTH'(outKind1));
                checkValue(testName, "outKind2", WIDTH'(exp.kind2), WIDTH'(outKind2));
                checkValue(testName, "outRd1", WIDTH'(exp.rd1), WIDTH'(outRd1));
                checkValue(testName, "outRd2", WIDTH'(exp.rd2), WIDTH'(outRd2));
                acceptCount++;
            end
            // what the coming edge does to the PCs in flight
            if (pcSrc1 != pcSeq || pcSrc2 != pcSeq) begin
                pcQueue.delete();
                pcQueue.push_back(expTarget());
            end else if (!stall) begin
                pcQueue.push_back(pcQueue[$] + WIDTH'(8));
            end
            // PC register plus two stages at most
            if (pcQueue.size() > 3) begin
                failRun("the DUT dropped a bundle that should have reached the outputs");
            end
        end
    end

    initial begin
        int          k;
        int unsigned r;
        logic [WIDTH-1:0] word;
        rst        = 1'b1;
        stall      = 1'b0;
        pcSrc1     = pcSeq;
        pcSrc2     = pcSeq;
        target1    = '0;
        aluResult1 = '0;
        target2    = '0;
        aluResult2 = '0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        // random program over every class, lui stands for the rest
        for (int i = 0; i < ROM_WORDS; i++) begin
            r    = $random(seed);
            k    = int'(r % 8);
            word = $random(seed);
            case (k)
                0:       word[6:0] = OPC_OP;
                1:       word[6:0] = OPC_OPIMM;
                2:       word[6:0] = OPC_LOAD;
                3:       word[6:0] = OPC_STORE;
                4:       word[6:0] = OPC_BRANCH;
                5:       word[6:0] = OPC_JAL;
                6:       word[6:0] = OPC_JALR;
                default: word[6:0] = 7'b0110111;
            endcase
            memModel[i] = word;
        end
        @(posedge clk);
        #1;
        // load under reset, one word per cycle
        for (int i = 0; i < ROM_WORDS; i++) begin
            progWe   = 1'b1;
            progAddr = ADDR_W'(i);
            progData = memModel[i];
            @(posedge clk);
            #1;
        end
        progWe = 1'b0;
        // reset held 5 more cycles after the load
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        runTest("sequential", 0, 0, 0, 0);
        runTest("slot1Redirect", 0, 6, 0, 0);
        runTest("slot2Redirect", 0, 0, 6, 0);
        runTest("dualRedirect", 0, 0, 0, 6);
        runTest("stall", 3, 10, 10, 20);
        // drain the pipe
        repeat (4) @(posedge clk);
        if (i_dualFetchFrontEnd.i_dualFetchFrontEnd_assert.failCount != 0) begin
            failRun("a bound assertion on the DUT fired");
        end else if (acceptCount < CYCLES_PER_TEST) begin
            failRun("too few bundles were accepted");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        failRun("timeout, the run did not finish in the expected time");
    end

endmodule

`default_nettype wire

// ==== dualFetchFrontEnd.f ====
logic/fetchPkg.sv
logic/fetchSlotIf.sv
logic/dualPcUnit.sv
logic/dualInstrRom.sv
logic/slotPredecode.sv
logic/dualFetchFrontEnd.sv
verification/dualFetchFrontEnd_assert.sv
verification/dualFetchFrontEnd_tb.sv
